// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f filelist.f \
		--top-module rename_tb -o rename_sim
	./obj_dir/rename_sim | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
rtl/rename_cfg_pkg.sv
rtl/dispatch_pkt_pkg.sv
rtl/dispatch.sv
rtl/free_list.sv
rtl/complete_list.sv
rtl/branch_stack.sv
rtl/rename_top.sv
verif/rename_tb.sv

// File: rtl/branch_stack.sv
`timescale 1ns/1ps

module branch_stack #(
    parameter int BS_DEPTH = 4
) (
    input  logic                                         clock,
    input  logic                                         reset,
    input  rename_cfg_pkg::b_mask_t                      cp_write,
    input  dispatch_pkt_pkg::checkpoint_t [BS_DEPTH-1:0] cp_data,
    input  logic                                         resolve_valid,
    input  rename_cfg_pkg::b_tag_t                       resolve_tag,
    input  logic                                         mispredict,
    output rename_cfg_pkg::b_mask_t                      b_mask_cur,
    output logic                                         branch_full,
    output logic                                         restore_valid,
    output dispatch_pkt_pkg::checkpoint_t                restore_cp
);

    dispatch_pkt_pkg::checkpoint_t [BS_DEPTH-1:0] cps;
    rename_cfg_pkg::b_mask_t                      b_mask;
    rename_cfg_pkg::b_mask_t                      clear_bit;
    rename_cfg_pkg::bs_state_e                    state;
    rename_cfg_pkg::bs_state_e                    state_next;

    assign restore_valid = resolve_valid && mispredict;
    assign restore_cp    = cps[resolve_tag];
    assign b_mask_cur    = b_mask;

    // Slot freed by a correctly predicted branch
    assign clear_bit = (resolve_valid && !mispredict) ?
                       rename_cfg_pkg::b_mask_t'(1) << resolve_tag : '0;

    // Front end must hold branches back for the cycle after a restore
    assign branch_full = (&b_mask) || (state == rename_cfg_pkg::BS_RESTORE);

    assign state_next = restore_valid ? rename_cfg_pkg::BS_RESTORE : rename_cfg_pkg::BS_IDLE;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= rename_cfg_pkg::BS_IDLE;
            b_mask <= '0;
        end else begin
            state <= state_next;
            if (restore_valid) begin
                b_mask <= restore_cp.b_mask;
            end else begin
                b_mask <= (b_mask | cp_write) & ~clear_bit;
            end
        end
    end

    // Older resolved branches also drop out of every stored mask
    always_ff @(posedge clock) begin
        for (int s = 0; s < BS_DEPTH; s++) begin
            if (cp_write[s]) begin
                cps[s] <= cp_data[s];
            end
            cps[s].b_mask <= (cp_write[s] ? cp_data[s].b_mask : cps[s].b_mask) & ~clear_bit;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        resolve_valid |-> b_mask[resolve_tag]);

endmodule

// File: rtl/complete_list.sv
`timescale 1ns/1ps

module complete_list #(
    parameter int WIDTH = 2
) (
    input  logic                               clock,
    input  logic                               reset,
    input  dispatch_pkt_pkg::cdb_t [WIDTH-1:0] cdb,
    input  rename_cfg_pkg::free_vec_t          alloc_mask,
    output rename_cfg_pkg::free_vec_t          ready_vec
);

    rename_cfg_pkg::free_vec_t ready_next;

    always_comb begin
        ready_next = ready_vec;
        for (int j = 0; j < WIDTH; j++) begin
            if (cdb[j].valid) begin
                ready_next[cdb[j].phys_reg] = 1'b1;
            end
        end
        // Allocation applied last so it wins
        ready_next = ready_next & ~alloc_mask;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < rename_cfg_pkg::NUM_PHYS_REGS; p++) begin
                ready_vec[p] <= (p < rename_cfg_pkg::NUM_ARCH_REGS);
            end
        end else begin
            ready_vec <= ready_next;
        end
    end

endmodule

// File: rtl/dispatch.sv
`timescale 1ns/1ps

module dispatch #(
    parameter int WIDTH    = 2,
    parameter int BS_DEPTH = 4
) (
    input  logic                                         clock,
    input  logic                                         reset,
    input  rename_cfg_pkg::disp_count_t                  inst_count,
    input  dispatch_pkt_pkg::decoded_inst_t [WIDTH-1:0]  inst,
    input  rename_cfg_pkg::disp_count_t                  rob_spots,
    input  rename_cfg_pkg::disp_count_t                  rs_spots,
    input  rename_cfg_pkg::phys_reg_t [WIDTH-1:0]        alloc_regs,
    input  rename_cfg_pkg::free_vec_t                    free_vec,
    input  rename_cfg_pkg::free_vec_t                    ready_vec,
    input  dispatch_pkt_pkg::cdb_t [WIDTH-1:0]           cdb,
    input  rename_cfg_pkg::b_mask_t                      b_mask_cur,
    input  logic                                         restore_valid,
    input  dispatch_pkt_pkg::checkpoint_t                restore_cp,
    output rename_cfg_pkg::disp_count_t                  num_dispatched,
    output dispatch_pkt_pkg::rob_entry_t [WIDTH-1:0]     rob_entries,
    output dispatch_pkt_pkg::rs_entry_t [WIDTH-1:0]      rs_entries,
    output rename_cfg_pkg::free_vec_t                    alloc_mask,
    output rename_cfg_pkg::b_mask_t                      cp_write,
    output dispatch_pkt_pkg::checkpoint_t [BS_DEPTH-1:0] cp_data
);

    rename_cfg_pkg::map_table_t  map_table;
    rename_cfg_pkg::map_table_t  run_map;
    rename_cfg_pkg::free_vec_t   run_free;
    rename_cfg_pkg::free_vec_t   run_ready;
    rename_cfg_pkg::b_mask_t     run_mask;
    rename_cfg_pkg::disp_count_t cap_rob;
    rename_cfg_pkg::disp_count_t limit;
    rename_cfg_pkg::phys_reg_t   t_new;
    logic                        stop;
    logic                        slot_found;

    // Unused sources count as ready; a tag on the result bus this cycle is ready too
    function automatic logic src_ready(
        input logic                               used,
        input rename_cfg_pkg::phys_reg_t          tag,
        input rename_cfg_pkg::free_vec_t          rdy,
        input dispatch_pkt_pkg::cdb_t [WIDTH-1:0] bus
    );
        logic r;
        r = !used || rdy[tag];
        for (int j = 0; j < WIDTH; j++) begin
            if (bus[j].valid && bus[j].phys_reg == tag) begin
                r = 1'b1;
            end
        end
        return r;
    endfunction

    assign cap_rob = (rob_spots < inst_count) ? rob_spots : inst_count;
    assign limit   = restore_valid ? '0 : ((rs_spots < cap_rob) ? rs_spots : cap_rob);

    // In-order walk over the bundle with running copies of map, free and ready state
    always_comb begin
        run_map        = map_table;
        run_free       = free_vec;
        run_ready      = ready_vec;
        run_mask       = b_mask_cur;
        num_dispatched = '0;
        rob_entries    = '0;
        rs_entries     = '0;
        alloc_mask     = '0;
        cp_write       = '0;
        cp_data        = '0;
        t_new          = '0;
        stop           = 1'b0;
        slot_found     = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            // A branch with no free slot blocks itself and everything younger
            if (i >= int'(limit) || (inst[i].is_branch && &run_mask)) begin
                stop = 1'b1;
            end
            if (!stop) begin
                t_new = alloc_regs[i];
                rs_entries[i].t_new      = t_new;
                rs_entries[i].src1_tag   = run_map[inst[i].src1];
                rs_entries[i].src1_ready = src_ready(inst[i].rs1_used,
                                                     run_map[inst[i].src1], run_ready, cdb);
                rs_entries[i].src2_tag   = run_map[inst[i].src2];
                rs_entries[i].src2_ready = src_ready(inst[i].rs2_used,
                                                     run_map[inst[i].src2], run_ready, cdb);
                rs_entries[i].b_mask     = run_mask;

                rob_entries[i].t_new    = t_new;
                rob_entries[i].t_old    = inst[i].has_dest ? run_map[inst[i].dest] : t_new;
                rob_entries[i].arch_reg = inst[i].dest;
                rob_entries[i].pc       = inst[i].pc;

                alloc_mask[t_new] = 1'b1;
                run_free[t_new]   = 1'b0;
                run_ready[t_new]  = 1'b0;
                if (inst[i].has_dest) begin
                    run_map[inst[i].dest] = t_new;
                end

                // Checkpoint taken after the branch's own rename, mask before its bit
                if (inst[i].is_branch) begin
                    slot_found = 1'b0;
                    for (int s = 0; s < BS_DEPTH; s++) begin
                        if (!slot_found && !run_mask[s]) begin
                            slot_found                  = 1'b1;
                            cp_write[s]                 = 1'b1;
                            cp_data[s].map_table        = run_map;
                            cp_data[s].free_list        = run_free;
                            cp_data[s].b_mask           = run_mask;
                            cp_data[s].recovery_pc      = inst[i].pc + 32'd4;
                            rs_entries[i].b_tag_mask[s] = 1'b1;
                        end
                    end
                    run_mask = run_mask | cp_write;
                end
                num_dispatched = num_dispatched + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < rename_cfg_pkg::NUM_ARCH_REGS; a++) begin
                map_table[a] <= rename_cfg_pkg::phys_reg_t'(a);
            end
        end else if (restore_valid) begin
            map_table <= restore_cp.map_table;
        end else begin
            map_table <= run_map;
        end
    end

    // Registers taken this cycle must all come from the free set
    assert property (@(posedge clock) disable iff (reset)
        num_dispatched <= inst_count && (alloc_mask & ~free_vec) == '0);

endmodule

// File: rtl/dispatch_pkt_pkg.sv
package dispatch_pkt_pkg;

    typedef struct packed {
        logic                      has_dest;
        logic                      is_branch;
        logic                      rs1_used;
        logic                      rs2_used;
        rename_cfg_pkg::arch_reg_t src1;
        rename_cfg_pkg::arch_reg_t src2;
        rename_cfg_pkg::arch_reg_t dest;
        logic [31:0]               pc;
    } decoded_inst_t;

    // t_old goes back to the free list when the entry retires
    typedef struct packed {
        rename_cfg_pkg::phys_reg_t t_new;
        rename_cfg_pkg::phys_reg_t t_old;
        rename_cfg_pkg::arch_reg_t arch_reg;
        logic [31:0]               pc;
    } rob_entry_t;

    typedef struct packed {
        rename_cfg_pkg::phys_reg_t t_new;
        rename_cfg_pkg::phys_reg_t src1_tag;
        logic                      src1_ready;
        rename_cfg_pkg::phys_reg_t src2_tag;
        logic                      src2_ready;
        rename_cfg_pkg::b_mask_t   b_mask;
        rename_cfg_pkg::b_mask_t   b_tag_mask;
    } rs_entry_t;

    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::phys_reg_t phys_reg;
    } cdb_t;

    typedef struct packed {
        rename_cfg_pkg::map_table_t map_table;
        rename_cfg_pkg::free_vec_t  free_list;
        rename_cfg_pkg::b_mask_t    b_mask;
        logic [31:0]                recovery_pc;
    } checkpoint_t;

endpackage

// File: rtl/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int WIDTH = 2
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  rename_cfg_pkg::free_vec_t             alloc_mask,
    input  logic                                  restore_valid,
    input  rename_cfg_pkg::free_vec_t             restore_free,
    input  logic                                  retire_valid,
    input  rename_cfg_pkg::phys_reg_t             retire_reg,
    output rename_cfg_pkg::phys_reg_t [WIDTH-1:0] alloc_regs,
    output rename_cfg_pkg::free_vec_t             free_vec
);

    rename_cfg_pkg::free_vec_t search;
    rename_cfg_pkg::free_vec_t free_next;

    // Repeated priority encode, each pass removing the register it found
    always_comb begin
        search     = free_vec;
        alloc_regs = '0;
        for (int k = 0; k < WIDTH; k++) begin
            for (int p = rename_cfg_pkg::NUM_PHYS_REGS - 1; p >= 0; p--) begin
                if (search[p]) begin
                    alloc_regs[k] = rename_cfg_pkg::phys_reg_t'(p);
                end
            end
            search[alloc_regs[k]] = 1'b0;
        end
    end

    // Retire release still applies on top of a restored vector
    always_comb begin
        free_next = restore_valid ? restore_free : (free_vec & ~alloc_mask);
        if (retire_valid) begin
            free_next[retire_reg] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Registers below the architectural count hold the identity mapping
            for (int p = 0; p < rename_cfg_pkg::NUM_PHYS_REGS; p++) begin
                free_vec[p] <= (p >= rename_cfg_pkg::NUM_ARCH_REGS);
            end
        end else begin
            free_vec <= free_next;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> !free_vec[retire_reg]);

endmodule

// File: rtl/rename_cfg_pkg.sv
package rename_cfg_pkg;

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;
    localparam int NUM_BS_SLOTS  = 4;

    typedef logic [4:0]               arch_reg_t;
    typedef logic [5:0]               phys_reg_t;
    typedef logic [NUM_BS_SLOTS-1:0]  b_mask_t;
    typedef logic [1:0]               b_tag_t;
    typedef logic [NUM_PHYS_REGS-1:0] free_vec_t;

    // Zero to two instructions per cycle
    typedef logic [1:0]               disp_count_t;

    // One physical tag per architectural register
    typedef phys_reg_t [NUM_ARCH_REGS-1:0] map_table_t;

    typedef enum logic {
        BS_IDLE,
        BS_RESTORE
    } bs_state_e;

endpackage

// File: rtl/rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int WIDTH    = 2,
    parameter int BS_DEPTH = 4
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rename_cfg_pkg::disp_count_t                 inst_count,
    input  dispatch_pkt_pkg::decoded_inst_t [WIDTH-1:0] inst,
    input  rename_cfg_pkg::disp_count_t                 rob_spots,
    input  rename_cfg_pkg::disp_count_t                 rs_spots,
    input  dispatch_pkt_pkg::cdb_t [WIDTH-1:0]          cdb,
    input  logic                                        resolve_valid,
    input  rename_cfg_pkg::b_tag_t                      resolve_tag,
    input  logic                                        mispredict,
    input  logic                                        retire_valid,
    input  rename_cfg_pkg::phys_reg_t                   retire_reg,
    output rename_cfg_pkg::disp_count_t                 num_dispatched,
    output dispatch_pkt_pkg::rob_entry_t [WIDTH-1:0]    rob_entries,
    output dispatch_pkt_pkg::rs_entry_t [WIDTH-1:0]     rs_entries,
    output logic                                        branch_full
);

    rename_cfg_pkg::phys_reg_t [WIDTH-1:0]        alloc_regs;
    rename_cfg_pkg::free_vec_t                    free_vec;
    rename_cfg_pkg::free_vec_t                    ready_vec;
    rename_cfg_pkg::free_vec_t                    alloc_mask;
    rename_cfg_pkg::b_mask_t                      b_mask_cur;
    rename_cfg_pkg::b_mask_t                      cp_write;
    dispatch_pkt_pkg::checkpoint_t [BS_DEPTH-1:0] cp_data;
    dispatch_pkt_pkg::checkpoint_t                restore_cp;
    logic                                         restore_valid;

    dispatch #(.WIDTH(WIDTH), .BS_DEPTH(BS_DEPTH)) u_dispatch (
        .clock          (clock),
        .reset          (reset),
        .inst_count     (inst_count),
        .inst           (inst),
        .rob_spots      (rob_spots),
        .rs_spots       (rs_spots),
        .alloc_regs     (alloc_regs),
        .free_vec       (free_vec),
        .ready_vec      (ready_vec),
        .cdb            (cdb),
        .b_mask_cur     (b_mask_cur),
        .restore_valid  (restore_valid),
        .restore_cp     (restore_cp),
        .num_dispatched (num_dispatched),
        .rob_entries    (rob_entries),
        .rs_entries     (rs_entries),
        .alloc_mask     (alloc_mask),
        .cp_write       (cp_write),
        .cp_data        (cp_data)
    );

    free_list #(.WIDTH(WIDTH)) u_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_mask    (alloc_mask),
        .restore_valid (restore_valid),
        .restore_free  (restore_cp.free_list),
        .retire_valid  (retire_valid),
        .retire_reg    (retire_reg),
        .alloc_regs    (alloc_regs),
        .free_vec      (free_vec)
    );

    complete_list #(.WIDTH(WIDTH)) u_complete_list (
        .clock      (clock),
        .reset      (reset),
        .cdb        (cdb),
        .alloc_mask (alloc_mask),
        .ready_vec  (ready_vec)
    );

    branch_stack #(.BS_DEPTH(BS_DEPTH)) u_branch_stack (
        .clock         (clock),
        .reset         (reset),
        .cp_write      (cp_write),
        .cp_data       (cp_data),
        .resolve_valid (resolve_valid),
        .resolve_tag   (resolve_tag),
        .mispredict    (mispredict),
        .b_mask_cur    (b_mask_cur),
        .branch_full   (branch_full),
        .restore_valid (restore_valid),
        .restore_cp    (restore_cp)
    );

endmodule

// File: verif/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam int WIDTH      = 2;
    localparam int BS_DEPTH   = 4;
    localparam int HALF       = 5;
    // Six tests take about 26 cycles including reset
    localparam int MAX_CYCLES = 200;

    logic                                        clock;
    logic                                        reset;
    rename_cfg_pkg::disp_count_t                 inst_count;
    dispatch_pkt_pkg::decoded_inst_t [WIDTH-1:0] inst;
    rename_cfg_pkg::disp_count_t                 rob_spots;
    rename_cfg_pkg::disp_count_t                 rs_spots;
    dispatch_pkt_pkg::cdb_t [WIDTH-1:0]          cdb;
    logic                                        resolve_valid;
    rename_cfg_pkg::b_tag_t                      resolve_tag;
    logic                                        mispredict;
    logic                                        retire_valid;
    rename_cfg_pkg::phys_reg_t                   retire_reg;
    rename_cfg_pkg::disp_count_t                 num_dispatched;
    dispatch_pkt_pkg::rob_entry_t [WIDTH-1:0]    rob_entries;
    dispatch_pkt_pkg::rs_entry_t [WIDTH-1:0]     rs_entries;
    logic                                        branch_full;

    // Reference model of the rename state
    int       m_map [32];
    bit       m_free [64];
    bit       m_ready [64];
    bit [3:0] m_mask;
    int       cp_map [BS_DEPTH][32];
    bit       cp_free [BS_DEPTH][64];
    bit [3:0] cp_mask [BS_DEPTH];

    int errors;
    int checks;
    int seed;
    int last_t_new [WIDTH];
    int last_slot;

    rename_top #(.WIDTH(WIDTH), .BS_DEPTH(BS_DEPTH)) u_dut (
        .clock          (clock),
        .reset          (reset),
        .inst_count     (inst_count),
        .inst           (inst),
        .rob_spots      (rob_spots),
        .rs_spots       (rs_spots),
        .cdb            (cdb),
        .resolve_valid  (resolve_valid),
        .resolve_tag    (resolve_tag),
        .mispredict     (mispredict),
        .retire_valid   (retire_valid),
        .retire_reg     (retire_reg),
        .num_dispatched (num_dispatched),
        .rob_entries    (rob_entries),
        .rs_entries     (rs_entries),
        .branch_full    (branch_full)
    );

    always #HALF clock = ~clock;

    task automatic check_val(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic drive_idle();
        inst_count    = '0;
        inst          = '0;
        rob_spots     = 2'd2;
        rs_spots      = 2'd2;
        cdb           = '0;
        resolve_valid = 1'b0;
        resolve_tag   = '0;
        mispredict    = 1'b0;
        retire_valid  = 1'b0;
        retire_reg    = '0;
    endtask

    task automatic set_inst(input int slot, input bit has_dest, input bit is_branch,
                            input int s1, input int s2, input int d);
        logic [31:0] pc;
        pc = $random(seed);
        inst[slot] = '{has_dest, is_branch, 1'b1, 1'b1, rename_cfg_pkg::arch_reg_t'(s1),
                       rename_cfg_pkg::arch_reg_t'(s2), rename_cfg_pkg::arch_reg_t'(d), pc};
    endtask

    task automatic model_reset();
        for (int a = 0; a < 32; a++) begin
            m_map[a] = a;
        end
        for (int p = 0; p < 64; p++) begin
            m_free[p]  = (p >= 32);
            m_ready[p] = (p < 32);
        end
        m_mask = '0;
    endtask

    function automatic int lowest_free();
        for (int p = 0; p < 64; p++) begin
            if (m_free[p]) begin
                return p;
            end
        end
        return -1;
    endfunction

    // Settles the cycle's inputs, checks every output against the model, then steps the model
    task automatic check_cycle();
        int lim;
        int n;
        int t;
        int s1;
        int s2;
        bit stop;
        #2;
        for (int j = 0; j < WIDTH; j++) begin
            if (cdb[j].valid) begin
                m_ready[cdb[j].phys_reg] = 1'b1;
            end
        end
        lim = int'(inst_count);
        lim = (int'(rob_spots) < lim) ? int'(rob_spots) : lim;
        lim = (int'(rs_spots) < lim) ? int'(rs_spots) : lim;
        lim = (resolve_valid && mispredict) ? 0 : lim;
        n = 0;
        stop = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (i >= lim || (inst[i].is_branch && m_mask == 4'hf)) begin
                stop = 1'b1;
            end
            if (!stop) begin
                t = lowest_free();
                s1 = m_map[inst[i].src1];
                s2 = m_map[inst[i].src2];
                last_t_new[i] = t;
                check_val($sformatf("rob_entries[%0d].t_new", i), t, rob_entries[i].t_new);
                check_val($sformatf("rob_entries[%0d].t_old", i),
                          inst[i].has_dest ? m_map[inst[i].dest] : t, rob_entries[i].t_old);
                check_val($sformatf("rob_entries[%0d].arch_reg", i), inst[i].dest,
                          rob_entries[i].arch_reg);
                check_val($sformatf("rob_entries[%0d].pc", i), inst[i].pc, rob_entries[i].pc);
                check_val($sformatf("rs_entries[%0d].t_new", i), t, rs_entries[i].t_new);
                check_val($sformatf("rs_entries[%0d].src1_tag", i), s1, rs_entries[i].src1_tag);
                check_val($sformatf("rs_entries[%0d].src1_ready", i),
                          !inst[i].rs1_used || m_ready[s1], rs_entries[i].src1_ready);
                check_val($sformatf("rs_entries[%0d].src2_tag", i), s2, rs_entries[i].src2_tag);
                check_val($sformatf("rs_entries[%0d].src2_ready", i),
                          !inst[i].rs2_used || m_ready[s2], rs_entries[i].src2_ready);
                check_val($sformatf("rs_entries[%0d].b_mask", i), m_mask, rs_entries[i].b_mask);
                m_free[t]  = 1'b0;
                m_ready[t] = 1'b0;
                if (inst[i].has_dest) begin
                    m_map[inst[i].dest] = t;
                end
                if (inst[i].is_branch) begin
                    // Lowest free slot, checkpoint after the branch's own rename
                    last_slot = 0;
                    while (m_mask[last_slot]) begin
                        last_slot++;
                    end
                    for (int a = 0; a < 32; a++) begin
                        cp_map[last_slot][a] = m_map[a];
                    end
                    for (int p = 0; p < 64; p++) begin
                        cp_free[last_slot][p] = m_free[p];
                    end
                    cp_mask[last_slot] = m_mask;
                    m_mask[last_slot] = 1'b1;
                end
                check_val($sformatf("rs_entries[%0d].b_tag_mask", i),
                          inst[i].is_branch ? (1 << last_slot) : 0, rs_entries[i].b_tag_mask);
                n++;
            end
        end
        check_val("num_dispatched", n, num_dispatched);
        if (resolve_valid && mispredict) begin
            for (int a = 0; a < 32; a++) begin
                m_map[a] = cp_map[resolve_tag][a];
            end
            for (int p = 0; p < 64; p++) begin
                m_free[p] = cp_free[resolve_tag][p];
            end
            m_mask = cp_mask[resolve_tag];
        end else if (resolve_valid) begin
            m_mask[resolve_tag] = 1'b0;
            for (int s = 0; s < BS_DEPTH; s++) begin
                cp_mask[s][resolve_tag] = 1'b0;
            end
        end
        if (retire_valid) begin
            m_free[retire_reg] = 1'b1;
        end
    endtask

    task automatic advance();
        @(negedge clock);
        drive_idle();
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("Test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "errors found");
    endtask

    task automatic test_basic_rename();
        int e0;
        e0 = errors;
        set_inst(0, 1, 0, 3, 4, 5);
        inst_count = 2'd1;
        check_cycle();
        check_val("rs_entries[0].src1_ready", 1, rs_entries[0].src1_ready);
        check_val("rs_entries[0].src2_ready", 1, rs_entries[0].src2_ready);
        check_val("rob_entries[0].t_new", 32, rob_entries[0].t_new);
        check_val("rob_entries[0].t_old", 5, rob_entries[0].t_old);
        advance();
        report_test(1, "basic rename", e0);
    endtask

    task automatic test_bundle_bypass();
        int e0;
        e0 = errors;
        set_inst(0, 1, 0, 1, 2, 6);
        set_inst(1, 1, 0, 6, 6, 8);
        // Second source names the same pending register but is unused
        inst[1].rs2_used = 1'b0;
        inst_count = 2'd2;
        check_cycle();
        check_val("rs_entries[1].src1_tag", last_t_new[0], rs_entries[1].src1_tag);
        check_val("rs_entries[1].src1_ready", 0, rs_entries[1].src1_ready);
        check_val("rs_entries[1].src2_ready", 1, rs_entries[1].src2_ready);
        advance();
        report_test(2, "in-bundle dependency", e0);
    endtask

    task automatic test_dispatch_limits();
        int e0;
        e0 = errors;
        set_inst(0, 0, 0, 1, 2, 0);
        set_inst(1, 0, 0, 1, 2, 0);
        inst_count = 2'd2;
        rob_spots  = 2'd1;
        check_cycle();
        check_val("num_dispatched", 1, num_dispatched);
        advance();
        set_inst(0, 0, 0, 1, 2, 0);
        set_inst(1, 0, 0, 1, 2, 0);
        inst_count = 2'd2;
        rs_spots   = 2'd0;
        check_cycle();
        check_val("num_dispatched", 0, num_dispatched);
        advance();
        // Fill all four branch-stack slots
        repeat (2) begin
            set_inst(0, 0, 1, 1, 2, 0);
            set_inst(1, 0, 1, 3, 4, 0);
            inst_count = 2'd2;
            check_cycle();
            advance();
        end
        set_inst(0, 0, 1, 1, 2, 0);
        inst_count = 2'd1;
        check_cycle();
        check_val("num_dispatched", 0, num_dispatched);
        check_val("branch_full", 1, branch_full);
        advance();
        for (int t = 0; t < BS_DEPTH; t++) begin
            resolve_valid = 1'b1;
            resolve_tag   = rename_cfg_pkg::b_tag_t'(t);
            check_cycle();
            advance();
        end
        report_test(3, "dispatch limits", e0);
    endtask

    task automatic test_completion();
        int e0;
        int x;
        e0 = errors;
        set_inst(0, 1, 0, 1, 2, 10);
        inst_count = 2'd1;
        check_cycle();
        x = last_t_new[0];
        advance();
        set_inst(0, 1, 0, 10, 2, 11);
        inst_count = 2'd1;
        check_cycle();
        check_val("rs_entries[0].src1_ready", 0, rs_entries[0].src1_ready);
        advance();
        // Completion on the bus in the same cycle as the read
        set_inst(0, 1, 0, 10, 2, 11);
        inst_count = 2'd1;
        cdb[0]     = '{1'b1, rename_cfg_pkg::phys_reg_t'(x)};
        check_cycle();
        check_val("rs_entries[0].src1_ready", 1, rs_entries[0].src1_ready);
        advance();
        set_inst(0, 1, 0, 10, 2, 12);
        inst_count = 2'd1;
        check_cycle();
        check_val("rs_entries[0].src1_ready", 1, rs_entries[0].src1_ready);
        advance();
        report_test(4, "completion ready", e0);
    endtask

    task automatic test_mispredict();
        int e0;
        int bslot;
        int after [3];
        e0 = errors;
        set_inst(0, 0, 1, 1, 2, 0);
        set_inst(1, 1, 0, 1, 2, 13);
        inst_count = 2'd2;
        check_cycle();
        bslot = last_slot;
        after[0] = last_t_new[1];
        advance();
        set_inst(0, 1, 0, 13, 2, 14);
        set_inst(1, 1, 0, 14, 13, 15);
        inst_count = 2'd2;
        check_cycle();
        after[1] = last_t_new[0];
        after[2] = last_t_new[1];
        advance();
        set_inst(0, 1, 0, 1, 2, 16);
        set_inst(1, 1, 0, 1, 2, 17);
        inst_count    = 2'd2;
        resolve_valid = 1'b1;
        resolve_tag   = rename_cfg_pkg::b_tag_t'(bslot);
        mispredict    = 1'b1;
        check_cycle();
        check_val("num_dispatched", 0, num_dispatched);
        advance();
        set_inst(0, 1, 0, 13, 14, 16);
        set_inst(1, 1, 0, 15, 16, 17);
        inst_count = 2'd2;
        check_cycle();
        check_val("branch_full", 1, branch_full);
        check_val("rob_entries[0].t_new", after[0], rob_entries[0].t_new);
        check_val("rob_entries[1].t_new", after[1], rob_entries[1].t_new);
        advance();
        report_test(5, "mispredict restore", e0);
    endtask

    task automatic test_retire();
        int e0;
        e0 = errors;
        retire_valid = 1'b1;
        retire_reg   = rename_cfg_pkg::phys_reg_t'(5);
        check_cycle();
        advance();
        set_inst(0, 1, 0, 1, 2, 18);
        inst_count = 2'd1;
        check_cycle();
        check_val("rob_entries[0].t_new", 5, rob_entries[0].t_new);
        advance();
        report_test(6, "retire release", e0);
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clock);
        $display("Watchdog timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed   = 2;
        errors = 0;
        checks = 0;
        clock  = 1'b0;
        reset  = 1'b1;
        drive_idle();
        model_reset();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_basic_rename();
        test_bundle_bypass();
        test_dispatch_limits();
        test_completion();
        test_mispredict();
        test_retire();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
